// File: hw/periph_pkg.sv
package periph_pkg;

    // Bus and address map
    localparam int ADDR_W    = 11;
    localparam int NUM_SLOTS = 16;
    localparam int OFFSET_W  = 6;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  size_t;
    typedef logic [3:0]  slot_idx_t;

    // Access size codes, shared by the read and write requests
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;
    localparam size_t SIZE_NONE = 2'd3;

    // Top two address bits that select the byte bank
    localparam logic [1:0] BYTE_BANK_TAG = 2'b10;

    // Populated slots
    localparam slot_idx_t SLOT_GPIO         = 4'd1;
    localparam slot_idx_t SLOT_SCRATCH_WORD = 4'd3;
    localparam slot_idx_t SLOT_SCRATCH_BYTE = 4'd0;

    // Output pin source: bank and slot
    typedef struct packed {
        logic      use_byte_bank;
        slot_idx_t slot_idx;
    } pin_func_t;

    // Decoded request seen by every slot
    typedef struct packed {
        logic [OFFSET_W-1:0] offset;
        word_t               wdata;
        size_t               wsize;
        logic                read;
    } bus_req_t;

    // One-hot slot selection, at most one bit set over both masks
    typedef struct packed {
        logic [NUM_SLOTS-1:0] word_sel;
        logic [NUM_SLOTS-1:0] byte_sel;
    } slot_sel_t;

endpackage

// File: hw/periph_bus_decode.sv
`timescale 1ns/1ps

module periph_bus_decode (
    input  logic [periph_pkg::ADDR_W-1:0] i_addr,
    input  periph_pkg::word_t             i_data_in,
    input  periph_pkg::size_t             i_data_write_n,
    input  periph_pkg::size_t             i_data_read_n,
    output periph_pkg::slot_sel_t         o_sel,
    output periph_pkg::bus_req_t          o_req
);
    import periph_pkg::*;

    logic      byte_bank;
    slot_idx_t slot;

    assign byte_bank = (i_addr[ADDR_W-1 -: 2] == BYTE_BANK_TAG);

    // Byte slots are 16 bytes wide, word slots 64 bytes
    assign slot = byte_bank ? i_addr[7:4] : i_addr[9:6];

    always_comb begin
        o_sel = '0;
        if (byte_bank) begin
            o_sel.byte_sel[slot] = 1'b1;
        end else begin
            o_sel.word_sel[slot] = 1'b1;
        end
    end

    // Byte slots only see the low four offset bits
    assign o_req.offset = byte_bank ? {2'b00, i_addr[3:0]} : i_addr[OFFSET_W-1:0];
    assign o_req.wdata  = i_data_in;
    assign o_req.wsize  = i_data_write_n;
    assign o_req.read   = (i_data_read_n != SIZE_NONE);

endmodule

// File: hw/periph_gpio.sv
`timescale 1ns/1ps

module periph_gpio #(
    parameter int NUM_PINS = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_sel_word,
    input  periph_pkg::bus_req_t  i_req,
    input  periph_pkg::byte_t     i_ui_in,
    output periph_pkg::word_t     o_rdata,
    output periph_pkg::byte_t     o_pins,
    output periph_pkg::pin_func_t o_func [NUM_PINS]
);
    import periph_pkg::*;

    // Register map within the slot
    localparam logic [OFFSET_W-1:0] OFS_GPIO_OUT = 6'd0;
    localparam logic [OFFSET_W-1:0] OFS_GPIO_IN  = 6'd4;

    byte_t     gpio_out;
    pin_func_t func_q [NUM_PINS];
    logic      wr_en;
    logic      func_hit;
    logic [2:0] func_idx;

    assign wr_en = i_sel_word && (i_req.wsize != SIZE_NONE);

    // Pin selects live at 32 + 4*n
    assign func_hit = i_req.offset[5] && (i_req.offset[1:0] == 2'b00);
    assign func_idx = i_req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && (i_req.offset == OFS_GPIO_OUT)) begin
            gpio_out <= i_req.wdata[7:0];
        end
    end

    for (genvar n = 0; n < NUM_PINS; n++) begin : g_func
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                // Every pin follows the GPIO output after reset
                func_q[n] <= '{use_byte_bank: 1'b0, slot_idx: SLOT_GPIO};
            end else if (wr_en && func_hit && (func_idx == 3'(n))) begin
                func_q[n] <= pin_func_t'(i_req.wdata[4:0]);
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_req.offset == OFS_GPIO_OUT) begin
            o_rdata = word_t'(gpio_out);
        end else if (i_req.offset == OFS_GPIO_IN) begin
            o_rdata = word_t'(i_ui_in);
        end else if (func_hit && (func_idx < NUM_PINS)) begin
            o_rdata = word_t'(func_q[func_idx]);
        end
    end

    assign o_pins = gpio_out;
    assign o_func = func_q;

endmodule

// File: hw/periph_scratch.sv
`timescale 1ns/1ps

module periph_scratch #(
    parameter type payload_t = periph_pkg::word_t
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_sel,
    input  periph_pkg::bus_req_t i_req,
    output payload_t             o_rdata,
    output periph_pkg::byte_t    o_pins
);
    import periph_pkg::*;

    payload_t data_q;
    word_t    lane_mask;
    logic     wr_en;

    assign wr_en = i_sel && (i_req.wsize != SIZE_NONE) && (i_req.offset == '0);

    // Lanes covered by the write size, clipped to the payload below
    always_comb begin
        case (i_req.wsize)
            SIZE_BYTE: lane_mask = 32'h0000_00ff;
            SIZE_HALF: lane_mask = 32'h0000_ffff;
            SIZE_WORD: lane_mask = 32'hffff_ffff;
            default:   lane_mask = 32'h0000_0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (wr_en) begin
            data_q <= (data_q & ~payload_t'(lane_mask)) |
                      (payload_t'(i_req.wdata) & payload_t'(lane_mask));
        end
    end

    assign o_rdata = data_q;
    assign o_pins  = byte_t'(data_q);

endmodule

// File: hw/periph_read_return.sv
`timescale 1ns/1ps

module periph_read_return (
    input  logic                   clk,
    input  logic                   rst_n,
    input  periph_pkg::slot_sel_t  i_sel,
    input  periph_pkg::bus_req_t   i_req,
    input  periph_pkg::word_t      i_word_rdata [periph_pkg::NUM_SLOTS],
    input  periph_pkg::byte_t      i_byte_rdata [periph_pkg::NUM_SLOTS],
    input  logic                   i_data_read_complete,
    output periph_pkg::word_t      o_data_out,
    output logic                   o_data_ready
);
    import periph_pkg::*;

    word_t slot_data;
    word_t data_q;
    logic  hold_q;
    logic  ready_q;
    logic  capture;

    // Selection is one-hot, so an OR of the gated slots is the mux
    always_comb begin
        slot_data = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (i_sel.word_sel[i]) begin
                slot_data = slot_data | i_word_rdata[i];
            end
            if (i_sel.byte_sel[i]) begin
                slot_data = slot_data | word_t'(i_byte_rdata[i]);
            end
        end
    end

    assign capture = i_req.read && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= i_req.read;
        end
    end

    // Frozen until the core signals read complete
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= slot_data;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_req.wsize != SIZE_NONE);

endmodule

// File: hw/periph_pin_mux.sv
`timescale 1ns/1ps

module periph_pin_mux #(
    parameter int NUM_PINS = 8
) (
    input  periph_pkg::pin_func_t i_func      [NUM_PINS],
    input  periph_pkg::byte_t     i_word_pins [periph_pkg::NUM_SLOTS],
    input  periph_pkg::byte_t     i_byte_pins [periph_pkg::NUM_SLOTS],
    output periph_pkg::byte_t     o_uo_out
);

    // Pin n only ever takes bit n of its source slot
    always_comb begin
        o_uo_out = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            if (i_func[n].use_byte_bank) begin
                o_uo_out[n] = i_byte_pins[i_func[n].slot_idx][n];
            end else begin
                o_uo_out[n] = i_word_pins[i_func[n].slot_idx][n];
            end
        end
    end

endmodule

// File: hw/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int NUM_PINS = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  periph_pkg::byte_t             i_ui_in,
    input  logic [periph_pkg::ADDR_W-1:0] i_addr,
    input  periph_pkg::word_t             i_data_in,
    input  periph_pkg::size_t             i_data_write_n,
    input  periph_pkg::size_t             i_data_read_n,
    input  logic                          i_data_read_complete,
    output periph_pkg::byte_t             o_uo_out,
    output periph_pkg::word_t             o_data_out,
    output logic                          o_data_ready
);
    import periph_pkg::*;

    slot_sel_t sel;
    bus_req_t  req;
    word_t     word_rdata [NUM_SLOTS];
    byte_t     byte_rdata [NUM_SLOTS];
    byte_t     word_pins  [NUM_SLOTS];
    byte_t     byte_pins  [NUM_SLOTS];
    pin_func_t pin_func   [NUM_PINS];

    periph_bus_decode u_bus_decode (
        .i_addr         (i_addr),
        .i_data_in      (i_data_in),
        .i_data_write_n (i_data_write_n),
        .i_data_read_n  (i_data_read_n),
        .o_sel          (sel),
        .o_req          (req)
    );

    periph_gpio #(
        .NUM_PINS (NUM_PINS)
    ) u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel_word (sel.word_sel[SLOT_GPIO]),
        .i_req      (req),
        .i_ui_in    (i_ui_in),
        .o_rdata    (word_rdata[SLOT_GPIO]),
        .o_pins     (word_pins[SLOT_GPIO]),
        .o_func     (pin_func)
    );

    periph_scratch #(
        .payload_t (word_t)
    ) u_scratch_word (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_sel   (sel.word_sel[SLOT_SCRATCH_WORD]),
        .i_req   (req),
        .o_rdata (word_rdata[SLOT_SCRATCH_WORD]),
        .o_pins  (word_pins[SLOT_SCRATCH_WORD])
    );

    periph_scratch #(
        .payload_t (byte_t)
    ) u_scratch_byte (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_sel   (sel.byte_sel[SLOT_SCRATCH_BYTE]),
        .i_req   (req),
        .o_rdata (byte_rdata[SLOT_SCRATCH_BYTE]),
        .o_pins  (byte_pins[SLOT_SCRATCH_BYTE])
    );

    // Empty slots read as zero and drive no pins
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_empty
        if (s != SLOT_GPIO && s != SLOT_SCRATCH_WORD) begin : g_word
            assign word_rdata[s] = '0;
            assign word_pins[s]  = '0;
        end
        if (s != SLOT_SCRATCH_BYTE) begin : g_byte
            assign byte_rdata[s] = '0;
            assign byte_pins[s]  = '0;
        end
    end

    periph_read_return u_read_return (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_sel                (sel),
        .i_req                (req),
        .i_word_rdata         (word_rdata),
        .i_byte_rdata         (byte_rdata),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    periph_pin_mux #(
        .NUM_PINS (NUM_PINS)
    ) u_pin_mux (
        .i_func      (pin_func),
        .i_word_pins (word_pins),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

// File: bench/periph_top_tb.sv
`timescale 1ns/1ps

module periph_top_tb;
    import periph_pkg::*;

    localparam int NUM_PINS = 8;
    localparam int TIMEOUT  = 50;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_HOLD} op_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        size_t             size;
        word_t             wdata;
        word_t             exp_data;
        byte_t             exp_pins;
    } entry_t;

    logic              clk;
    logic              rst_n;
    byte_t             ui_in;
    logic [ADDR_W-1:0] addr;
    word_t             data_in;
    size_t             write_n;
    size_t             read_n;
    logic              read_complete;
    byte_t             uo_out;
    word_t             data_out;
    logic              data_ready;

    int        checks;
    int        errors;
    int        timeouts;
    entry_t    stim [$];

    // Reference state of the populated slots, built from the register map
    byte_t     gpio_ref;
    word_t     scratch_word_ref;
    byte_t     scratch_byte_ref;
    pin_func_t func_ref [NUM_PINS];

    periph_top #(
        .NUM_PINS (NUM_PINS)
    ) u_periph_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_uo_out             (uo_out),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [ADDR_W-1:0] word_addr(slot_idx_t s, logic [5:0] ofs);
        return {1'b0, s, ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(slot_idx_t s, logic [3:0] ofs);
        return {BYTE_BANK_TAG, 1'b0, s, ofs};
    endfunction

    // Pin n shows bit n of the pin byte of the slot its select names
    function automatic byte_t pins_now();
        byte_t src;
        byte_t pins;
        pins = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            if (func_ref[n].use_byte_bank) begin
                src = (func_ref[n].slot_idx == SLOT_SCRATCH_BYTE) ? scratch_byte_ref : 8'h00;
            end else if (func_ref[n].slot_idx == SLOT_GPIO) begin
                src = gpio_ref;
            end else if (func_ref[n].slot_idx == SLOT_SCRATCH_WORD) begin
                src = scratch_word_ref[7:0];
            end else begin
                src = 8'h00;
            end
            pins[n] = src[n];
        end
        return pins;
    endfunction

    task automatic add_entry(input op_t op, input logic [ADDR_W-1:0] a, input size_t sz,
                             input word_t wd, input word_t ed);
        entry_t e;
        e.op       = op;
        e.addr     = a;
        e.size     = sz;
        e.wdata    = wd;
        e.exp_data = ed;
        e.exp_pins = pins_now();
        stim.push_back(e);
    endtask

    task automatic route_pin(input int n, input pin_func_t f);
        func_ref[n] = f;
        add_entry(OP_WR, word_addr(SLOT_GPIO, 6'(32 + 4 * n)), SIZE_WORD, word_t'(f), '0);
    endtask

    task automatic build_stimulus();
        word_t rnd;
        word_t old;
        for (int n = 0; n < NUM_PINS; n++) begin
            add_entry(OP_RD, word_addr(SLOT_GPIO, 6'(32 + 4 * n)), SIZE_WORD, '0,
                      word_t'(func_ref[n]));
        end
        rnd = $urandom();
        gpio_ref = rnd[7:0];
        add_entry(OP_WR, word_addr(SLOT_GPIO, 6'd0), SIZE_WORD, rnd, '0);
        add_entry(OP_RD, word_addr(SLOT_GPIO, 6'd0), SIZE_WORD, '0, word_t'(gpio_ref));
        add_entry(OP_RD, word_addr(SLOT_GPIO, 6'd4), SIZE_WORD, '0, word_t'(ui_in));
        // Word scratch, then narrower writes on top
        rnd = $urandom();
        scratch_word_ref = rnd;
        add_entry(OP_WR, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_WORD, rnd, '0);
        rnd = $urandom();
        scratch_word_ref[7:0] = rnd[7:0];
        add_entry(OP_WR, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_BYTE, rnd, '0);
        add_entry(OP_RD, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_WORD, '0, scratch_word_ref);
        rnd = $urandom();
        scratch_word_ref[15:0] = rnd[15:0];
        add_entry(OP_WR, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_HALF, rnd, '0);
        add_entry(OP_RD, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_WORD, '0, scratch_word_ref);
        rnd = $urandom();
        scratch_byte_ref = rnd[7:0];
        add_entry(OP_WR, byte_addr(SLOT_SCRATCH_BYTE, 4'd0), SIZE_WORD, rnd, '0);
        add_entry(OP_RD, byte_addr(SLOT_SCRATCH_BYTE, 4'd0), SIZE_WORD, '0,
                  word_t'(scratch_byte_ref));
        // Pins 2 and 3 to the word scratch, 5 and 6 to the byte scratch
        route_pin(2, '{use_byte_bank: 1'b0, slot_idx: SLOT_SCRATCH_WORD});
        route_pin(3, '{use_byte_bank: 1'b0, slot_idx: SLOT_SCRATCH_WORD});
        route_pin(5, '{use_byte_bank: 1'b1, slot_idx: SLOT_SCRATCH_BYTE});
        route_pin(6, '{use_byte_bank: 1'b1, slot_idx: SLOT_SCRATCH_BYTE});
        add_entry(OP_RD, word_addr(SLOT_GPIO, 6'd52), SIZE_WORD, '0, word_t'(func_ref[5]));
        add_entry(OP_RD, word_addr(4'd0, 6'd0), SIZE_WORD, '0, '0);
        add_entry(OP_RD, word_addr(4'd9, 6'd8), SIZE_WORD, '0, '0);
        add_entry(OP_RD, byte_addr(4'd15, 4'd0), SIZE_WORD, '0, '0);
        old = scratch_word_ref;
        rnd = $urandom();
        scratch_word_ref = rnd;
        add_entry(OP_HOLD, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_WORD, rnd, old);
        add_entry(OP_RD, word_addr(SLOT_SCRATCH_WORD, 6'd0), SIZE_WORD, '0, scratch_word_ref);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pins(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] a, input size_t sz, input word_t wd);
        @(posedge clk);
        addr    <= a;
        data_in <= wd;
        write_n <= sz;
        @(negedge clk);
        check_flag("o_data_ready", data_ready, 1'b1);
        @(posedge clk);
        write_n <= SIZE_NONE;
    endtask

    // Returns with the read request still up and the data sampled
    task automatic start_read(input logic [ADDR_W-1:0] a, input word_t exp);
        int count;
        count = 0;
        @(posedge clk);
        addr   <= a;
        read_n <= SIZE_WORD;
        @(negedge clk);
        while (data_ready !== 1'b1 && count < TIMEOUT) begin
            @(negedge clk);
            count++;
        end
        if (data_ready === 1'b1) begin
            check_word("o_data_out", data_out, exp);
        end else begin
            timeouts++;
            $display("Timeout waiting for o_data_ready on a read from address %h", a);
        end
    endtask

    task automatic finish_read();
        @(posedge clk);
        read_complete <= 1'b1;
        read_n        <= SIZE_NONE;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        case (e.op)
            OP_WR: begin
                do_write(e.addr, e.size, e.wdata);
            end
            OP_RD: begin
                start_read(e.addr, e.exp_data);
                finish_read();
            end
            OP_HOLD: begin
                // Request stays up through the write so only the hold keeps the data
                start_read(e.addr, e.exp_data);
                do_write(e.addr, e.size, e.wdata);
                // Captured value stays until read complete
                repeat (2) @(negedge clk);
                check_word("o_data_out", data_out, e.exp_data);
                finish_read();
            end
            default: begin
                $display("Unknown operation in the stimulus table");
                errors++;
            end
        endcase
        @(negedge clk);
        check_pins("o_uo_out", uo_out, e.exp_pins);
    endtask

    initial begin
        void'($urandom(60136));
        rst_n         = 1'b0;
        ui_in         = 8'($urandom());
        addr          = '0;
        data_in       = '0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        gpio_ref         = '0;
        scratch_word_ref = '0;
        scratch_byte_ref = '0;
        for (int n = 0; n < NUM_PINS; n++) begin
            func_ref[n] = '{use_byte_bank: 1'b0, slot_idx: SLOT_GPIO};
        end
        build_stimulus();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_pins("o_uo_out", uo_out, 8'h00);
        check_flag("o_data_ready", data_ready, 1'b0);
        foreach (stim[i]) begin
            apply_entry(stim[i]);
        end
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: periph_top.f
hw/periph_pkg.sv
hw/periph_bus_decode.sv
hw/periph_gpio.sv
hw/periph_scratch.sv
hw/periph_read_return.sv
hw/periph_pin_mux.sv
hw/periph_top.sv
bench/periph_top_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := periph_top_tb
RTL_TOP    := periph_top
FILELIST   := periph_top.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
